// File: datapath.f
busPkg.sv
isaPkg.sv
registerFile.sv
busEncoder.sv
alu.sv
specialRegisters.sv
datapath.sv
clockGen.sv
datapath_props.sv
datapathTb.sv

// File: Makefile
SIM = obj_dir/VdatapathTb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --assert --timing --top-module datapathTb -f datapath.f
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// File: datapathTb.sv
`default_nettype none

module datapathTb;
	import busPkg::*;
	import isaPkg::*;

	localparam int NumRegs = 16;
	localparam int Period = 40;
	localparam int ResetCycles = 2;
	localparam int DriveDelay = 5;
	localparam int Seed = 68788;
	localparam int CountBits = $clog2(WordWidth);
	// transfers, ten ALU ops, mul, fetch, immediate and priority steps.
	localparam int StepCount = (NumRegs + 3) + 10 * 6 + 8 + 6 + 3 + 5;
	localparam int Timeout = (StepCount + ResetCycles + 20) * Period;

	logic Clock;
	logic reset;
	logic [NumRegs-1:0] regIn;
	logic [NumRegs-1:0] regOut;
	logic hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn;
	logic hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, immOut;
	logic read;
	logic incPc;
	aluOp opcode;
	logic [WordWidth-1:0] memData;
	logic [WordWidth-1:0] inPortData;
	logic [WordWidth-1:0] busData;
	logic [WordWidth-1:0] marAddress;
	instructionWord irWord;
	int checks = 0;
	int failures = 0;
	int testChecks = 0;
	int testFailures = 0;
	int testsRun = 0;

	clockGen #(.Period(Period), .ResetCycles(ResetCycles)) clocks (.Clock, .reset);

	datapath #(.NumRegs(NumRegs)) UUT (
		.Clock, .reset, .regIn, .hiIn, .loIn, .yIn, .zIn, .pcIn, .irIn, .marIn, .mdrIn,
		.regOut, .hiOut, .loOut, .zHighOut, .zLowOut, .pcOut, .mdrOut, .inPortOut, .immOut,
		.read, .incPc, .opcode, .memData, .inPortData, .busData, .marAddress, .irWord
	);

	task automatic clearStrobes();
		regIn = '0;
		regOut = '0;
		{hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn} = '0;
		{hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, immOut} = '0;
		{read, incPc} = '0;
		opcode = opAdd;
		memData = '0;
		inPortData = '0;
	endtask

	// inputs change just after the rising edge and are settled by the falling one.
	task automatic nextStep();
		@(posedge Clock);
		#DriveDelay;
		clearStrobes();
	endtask

	task automatic checkValue(input logic [WordWidth-1:0] actual,
		input logic [WordWidth-1:0] expected, input string what);
		testChecks++;
		assert (actual == expected) else begin
			testFailures++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, actual, expected);
		end
	endtask

	task automatic endTest(input string name);
		$display("%s: %0d checks, %0d failed", name, testChecks, testFailures);
		checks += testChecks;
		failures += testFailures;
		testChecks = 0;
		testFailures = 0;
		testsRun++;
	endtask

	task automatic loadRegister(input int index, input logic [WordWidth-1:0] value);
		nextStep();
		inPortData = value;
		inPortOut = 1'b1;
		regIn[index] = 1'b1;
	endtask

	task automatic readRegister(input int index, input logic [WordWidth-1:0] expected,
		input string what);
		nextStep();
		regOut[index] = 1'b1;
		@(negedge Clock);
		checkValue(busData, expected, what);
	endtask

	// operands go to R1 and R2, then the Y step and the Z step.
	task automatic runAlu(input aluOp op, input logic [WordWidth-1:0] a,
		input logic [WordWidth-1:0] b);
		loadRegister(1, a);
		loadRegister(2, b);
		nextStep();
		regOut[1] = 1'b1;
		yIn = 1'b1;
		nextStep();
		regOut[2] = 1'b1;
		zIn = 1'b1;
		opcode = op;
	endtask

	function automatic logic [WordWidth-1:0] rotateLeft(input logic [WordWidth-1:0] value,
		input int count);
		logic [WordWidth-1:0] rotated;
		rotated = value;
		for (int i = 0; i < count; i++) begin
			rotated = {rotated[WordWidth-2:0], rotated[WordWidth-1]};
		end
		return rotated;
	endfunction

	// expected low word, with Y as A and the bus as B.
	function automatic logic [WordWidth-1:0] expectedLow(input aluOp op,
		input logic [WordWidth-1:0] a, input logic [WordWidth-1:0] b);
		int count;
		count = int'(b[CountBits-1:0]);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opRor: return rotateLeft(a, (WordWidth - count) % WordWidth);
			opRol: return rotateLeft(a, count);
			opShr: return a >> count;
			opShl: return a << count;
			opNeg: return -b;
			opNot: return ~b;
			default: return '0;
		endcase
	endfunction

	task automatic resetAndTransfers();
		logic [WordWidth-1:0] value;
		@(negedge Clock);
		checkValue(busData, '0, "bus during reset");
		checkValue(marAddress, '0, "MAR during reset");
		wait (reset == 1'b0);
		for (int r = 0; r < NumRegs; r++) begin
			readRegister(r, '0, $sformatf("R%0d after reset", r));
		end
		value = $urandom;
		nextStep();
		memData = value;
		read = 1'b1;
		mdrIn = 1'b1;
		nextStep();
		mdrOut = 1'b1;
		regIn[5] = 1'b1;
		readRegister(5, value, "R5 loaded from memory");
		endTest("reset and transfers");
	endtask

	task automatic registerOps();
		aluOp ops [10];
		logic [WordWidth-1:0] a;
		logic [WordWidth-1:0] b;
		ops = '{opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShl, opNeg, opNot};
		foreach (ops[i]) begin
			a = $urandom;
			b = $urandom;
			runAlu(ops[i], a, b);
			nextStep();
			zLowOut = 1'b1;
			regIn[3] = 1'b1;
			readRegister(3, expectedLow(ops[i], a, b), $sformatf("%s into R3", ops[i].name()));
		end
		endTest("ALU register operations");
	endtask

	task automatic multiply();
		logic [WordWidth-1:0] a;
		logic [WordWidth-1:0] b;
		longint product;
		a = $urandom;
		b = $urandom;
		product = longint'($signed(a)) * longint'($signed(b));
		runAlu(opMul, a, b);
		nextStep();
		zHighOut = 1'b1;
		hiIn = 1'b1;
		nextStep();
		zLowOut = 1'b1;
		loIn = 1'b1;
		nextStep();
		hiOut = 1'b1;
		@(negedge Clock);
		checkValue(busData, product[2*WordWidth-1:WordWidth], "HI after mul");
		nextStep();
		loOut = 1'b1;
		@(negedge Clock);
		checkValue(busData, product[WordWidth-1:0], "LO after mul");
		endTest("signed multiply");
	endtask

	task automatic fetchSequence();
		logic [WordWidth-1:0] oldPc;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		oldPc = $urandom;
		ra = 4'($urandom);
		rb = 4'($urandom);
		rc = 4'($urandom);
		nextStep();
		inPortData = oldPc;
		inPortOut = 1'b1;
		pcIn = 1'b1;
		nextStep();
		pcOut = 1'b1;
		marIn = 1'b1;
		incPc = 1'b1;
		zIn = 1'b1;
		nextStep();
		zLowOut = 1'b1;
		pcIn = 1'b1;
		nextStep();
		memData = {opSub, ra, rb, rc, 15'd0};
		read = 1'b1;
		mdrIn = 1'b1;
		nextStep();
		mdrOut = 1'b1;
		irIn = 1'b1;
		nextStep();
		pcOut = 1'b1;
		@(negedge Clock);
		checkValue(marAddress, oldPc, "MAR after fetch");
		checkValue(busData, oldPc + WordWidth'(1), "PC after fetch");
		checkValue(WordWidth'(irWord.asReg.opcode), WordWidth'(opSub), "IR opcode");
		checkValue(WordWidth'(irWord.asReg.ra), WordWidth'(ra), "IR ra");
		checkValue(WordWidth'(irWord.asReg.rb), WordWidth'(rb), "IR rb");
		checkValue(WordWidth'(irWord.asReg.rc), WordWidth'(rc), "IR rc");
		endTest("fetch sequence");
	endtask

	task automatic immediateFormat();
		int constant;
		logic [3:0] rb;
		constant = -int'($urandom_range(1, 2 ** (ConstWidth - 1)));
		rb = 4'($urandom);
		nextStep();
		memData = {opAdd, 4'd2, rb, constant[ConstWidth-1:0]};
		read = 1'b1;
		mdrIn = 1'b1;
		nextStep();
		mdrOut = 1'b1;
		irIn = 1'b1;
		nextStep();
		immOut = 1'b1;
		@(negedge Clock);
		checkValue(busData, constant, "sign-extended constant");
		checkValue(WordWidth'(irWord.asImm.rb), WordWidth'(rb), "immediate rb");
		endTest("immediate format");
	endtask

	// R3 ranks above HI, and HI above PC.
	task automatic sourcePriority();
		logic [WordWidth-1:0] regValue;
		logic [WordWidth-1:0] hiValue;
		logic [WordWidth-1:0] regOverHi;
		logic [WordWidth-1:0] hiOverPc;
		regValue = $urandom;
		hiValue = $urandom;
		loadRegister(3, regValue);
		nextStep();
		inPortData = hiValue;
		inPortOut = 1'b1;
		hiIn = 1'b1;
		$assertoff;
		nextStep();
		regOut[3] = 1'b1;
		hiOut = 1'b1;
		@(negedge Clock);
		regOverHi = busData;
		nextStep();
		hiOut = 1'b1;
		pcOut = 1'b1;
		@(negedge Clock);
		hiOverPc = busData;
		nextStep();
		$asserton;
		checkValue(regOverHi, regValue, "bus with R3 and HI requested");
		checkValue(hiOverPc, hiValue, "bus with HI and PC requested");
		endTest("source priority");
	endtask

	initial begin
		void'($urandom(Seed));
		clearStrobes();
		resetAndTransfers();
		registerOps();
		multiply();
		fetchSequence();
		immediateFormat();
		sourcePriority();
		failures += UUT.props.failCount; // bound property failures count too.
		$display("%0d tests, %0d checks, %0d failed", testsRun, checks, failures);
		if (failures == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(Timeout);
		$display("watchdog expired, the tests did not finish within %0d time units", Timeout);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: datapath_props.sv
`default_nettype none

module datapathProps #(
	parameter int NumRegs = 16
) (
	input logic Clock,
	input logic reset,
	input logic [NumRegs-1:0] regOut,
	input logic hiOut, loOut, zHighOut, zLowOut,
	input logic pcOut, mdrOut, inPortOut, immOut,
	input logic read,
	input logic mdrIn
);

	logic [NumRegs+7:0] outStrobes;
	int failCount = 0;

	assign outStrobes = {regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, immOut};

	// the encoder settles clashes, but a normal step asks for one source at most.
	oneSource: assert property (@(posedge Clock) disable iff (reset) $onehot0(outStrobes))
		else begin
			failCount++;
			$error("more than one bus source requested: %b", outStrobes);
		end

	readLoadsMdr: assert property (@(posedge Clock) disable iff (reset) read |-> mdrIn)
		else begin
			failCount++;
			$error("memory read without an MDR load");
		end

endmodule

bind datapath datapathProps #(.NumRegs(NumRegs)) props (
	.Clock(Clock), .reset(reset), .regOut(regOut),
	.hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
	.pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .immOut(immOut),
	.read(read), .mdrIn(mdrIn)
);

`default_nettype wire

// File: clockGen.sv
`default_nettype none

module clockGen #(
	parameter int Period = 40,
	parameter int ResetCycles = 2
) (
	output logic Clock,
	output logic reset
);

	initial begin
		Clock = 1'b0;
		reset = 1'b1;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0; // released away from the rising edge.
	end

	always #(Period / 2) Clock = ~Clock;

endmodule

`default_nettype wire

// File: datapath.sv
`default_nettype none

module datapath #(
	parameter int NumRegs = 16
) (
	input logic Clock,
	input logic reset,
	input logic [NumRegs-1:0] regIn,
	input logic hiIn,
	input logic loIn,
	input logic yIn,
	input logic zIn,
	input logic pcIn,
	input logic irIn,
	input logic marIn,
	input logic mdrIn,
	input logic [NumRegs-1:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic immOut,
	input logic read,
	input logic incPc,
	input isaPkg::aluOp opcode,
	input logic [busPkg::WordWidth-1:0] memData,
	input logic [busPkg::WordWidth-1:0] inPortData,
	output logic [busPkg::WordWidth-1:0] busData,
	output logic [busPkg::WordWidth-1:0] marAddress,
	output isaPkg::instructionWord irWord
);
	import busPkg::*;

	logic [WordWidth-1:0] regContents [NumRegs];
	logic [WordWidth-1:0] hi;
	logic [WordWidth-1:0] lo;
	logic [WordWidth-1:0] y;
	logic [WordWidth-1:0] zHigh;
	logic [WordWidth-1:0] zLow;
	logic [WordWidth-1:0] pc;
	logic [WordWidth-1:0] mdr;
	logic [WordWidth-1:0] immediate;
	logic [2*WordWidth-1:0] aluResult;

	registerFile #(.NumRegs(NumRegs)) regs (
		.Clock, .reset, .busData, .regIn, .regContents
	);

	busEncoder #(.NumRegs(NumRegs)) encoder (
		.regContents, .regOut,
		.hiOut, .loOut, .zHighOut, .zLowOut, .pcOut, .mdrOut, .inPortOut, .immOut,
		.hi, .lo, .zHigh, .zLow, .pc, .mdr,
		.inPort(inPortData), // input port is sampled straight onto the bus.
		.immediate, .busData
	);

	alu alu (
		.opcode, .incPc,
		.operandA(y), // Y holds the first operand.
		.operandB(busData),
		.pc,
		.result(aluResult)
	);

	specialRegisters special (
		.Clock, .reset, .busData, .memData, .read,
		.hiIn, .loIn, .yIn, .zIn, .pcIn, .irIn, .marIn, .mdrIn,
		.aluResult,
		.hi, .lo, .y, .zHigh, .zLow, .pc, .mdr, .marAddress,
		.immediate, .irWord
	);

endmodule

`default_nettype wire

// File: specialRegisters.sv
`default_nettype none

module specialRegisters (
	input logic Clock,
	input logic reset,
	input logic [busPkg::WordWidth-1:0] busData,
	input logic [busPkg::WordWidth-1:0] memData,
	input logic read,
	input logic hiIn,
	input logic loIn,
	input logic yIn,
	input logic zIn,
	input logic pcIn,
	input logic irIn,
	input logic marIn,
	input logic mdrIn,
	input logic [2*busPkg::WordWidth-1:0] aluResult,
	output logic [busPkg::WordWidth-1:0] hi,
	output logic [busPkg::WordWidth-1:0] lo,
	output logic [busPkg::WordWidth-1:0] y,
	output logic [busPkg::WordWidth-1:0] zHigh,
	output logic [busPkg::WordWidth-1:0] zLow,
	output logic [busPkg::WordWidth-1:0] pc,
	output logic [busPkg::WordWidth-1:0] mdr,
	output logic [busPkg::WordWidth-1:0] marAddress,
	output logic [busPkg::WordWidth-1:0] immediate,
	output isaPkg::instructionWord irWord
);
	import busPkg::*;
	import isaPkg::*;

	always_ff @(posedge Clock) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
			y <= '0;
			zHigh <= '0;
			zLow <= '0;
			pc <= '0;
			mdr <= '0;
			marAddress <= '0;
			irWord <= '0;
		end else begin
			if (hiIn) hi <= busData;
			if (loIn) lo <= busData;
			if (yIn) y <= busData;
			if (zIn) {zHigh, zLow} <= aluResult; // Z takes the full 64-bit result.
			if (pcIn) pc <= busData;
			if (marIn) marAddress <= busData;
			if (irIn) irWord <= busData;
			if (mdrIn) begin
				mdr <= read ? memData : busData; // memory side wins while reading.
			end
		end
	end

	// immediate format view of IR, constant widened with its sign.
	assign immediate = {{(WordWidth - ConstWidth){irWord.asImm.constant[ConstWidth-1]}},
		irWord.asImm.constant};

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
	input isaPkg::aluOp opcode,
	input logic incPc,
	input logic [busPkg::WordWidth-1:0] operandA,
	input logic [busPkg::WordWidth-1:0] operandB,
	input logic [busPkg::WordWidth-1:0] pc,
	output logic [2*busPkg::WordWidth-1:0] result
);
	import busPkg::*;
	import isaPkg::*;

	localparam int CountWidth = $clog2(WordWidth);

	logic [CountWidth-1:0] count;
	logic [2*WordWidth-1:0] doubled;
	logic [2*WordWidth-1:0] rotRight;
	logic [2*WordWidth-1:0] rotLeft;
	logic [2*WordWidth-1:0] wideA;
	logic [2*WordWidth-1:0] wideB;
	logic [2*WordWidth-1:0] product;
	logic [WordWidth-1:0] lowWord;

	assign count = operandB[CountWidth-1:0]; // shift count modulo the word width.

	// rotates fall out of shifting two copies of A side by side.
	assign doubled = {operandA, operandA};
	assign rotRight = doubled >> count;
	assign rotLeft = doubled << count;

	// sign-extended operands give the signed product in the low 64 bits.
	assign wideA = {{WordWidth{operandA[WordWidth-1]}}, operandA};
	assign wideB = {{WordWidth{operandB[WordWidth-1]}}, operandB};
	assign product = wideA * wideB;

	always_comb begin
		lowWord = '0;
		case (opcode)
			opAdd: lowWord = operandA + operandB;
			opSub: lowWord = operandA - operandB;
			opAnd: lowWord = operandA & operandB;
			opOr: lowWord = operandA | operandB;
			opRor: lowWord = rotRight[WordWidth-1:0];
			opRol: lowWord = rotLeft[2*WordWidth-1:WordWidth];
			opShr: lowWord = operandA >> count; // logical.
			opShl: lowWord = operandA << count;
			opMul: lowWord = product[WordWidth-1:0];
			opNeg: lowWord = -operandB; // neg and not act on the bus operand.
			opNot: lowWord = ~operandB;
			default: lowWord = '0;
		endcase
		if (incPc) begin
			lowWord = pc + WordWidth'(1); // fetch step overrides the opcode.
		end
	end

	always_comb begin
		if (!incPc && opcode == opMul) begin
			result = product;
		end else begin
			result = {{WordWidth{lowWord[WordWidth-1]}}, lowWord};
		end
	end

endmodule

`default_nettype wire

// File: busEncoder.sv
`default_nettype none

module busEncoder #(
	parameter int NumRegs = 16
) (
	input logic [busPkg::WordWidth-1:0] regContents [NumRegs],
	input logic [NumRegs-1:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic immOut,
	input logic [busPkg::WordWidth-1:0] hi,
	input logic [busPkg::WordWidth-1:0] lo,
	input logic [busPkg::WordWidth-1:0] zHigh,
	input logic [busPkg::WordWidth-1:0] zLow,
	input logic [busPkg::WordWidth-1:0] pc,
	input logic [busPkg::WordWidth-1:0] mdr,
	input logic [busPkg::WordWidth-1:0] inPort,
	input logic [busPkg::WordWidth-1:0] immediate,
	output logic [busPkg::WordWidth-1:0] busData
);
	import busPkg::*;

	localparam int IndexWidth = $clog2(NumRegs);

	busSource grant;

	// checked from the lowest priority up, so a lower index overwrites a higher one.
	always_comb begin
		grant = srcNone;
		if (immOut) grant = srcImmediate;
		if (inPortOut) grant = srcInPort;
		if (mdrOut) grant = srcMdr;
		if (pcOut) grant = srcPc;
		if (zLowOut) grant = srcZLow;
		if (zHighOut) grant = srcZHigh;
		if (loOut) grant = srcLo;
		if (hiOut) grant = srcHi;
		for (int i = NumRegs - 1; i >= 0; i--) begin
			if (regOut[i]) grant = busSource'(i);
		end
	end

	always_comb begin
		busData = '0; // idle bus reads zero.
		case (grant)
			srcHi: busData = hi;
			srcLo: busData = lo;
			srcZHigh: busData = zHigh;
			srcZLow: busData = zLow;
			srcPc: busData = pc;
			srcMdr: busData = mdr;
			srcInPort: busData = inPort;
			srcImmediate: busData = immediate;
			srcNone: busData = '0;
			default: begin
				if (int'(grant) < NumRegs) busData = regContents[grant[IndexWidth-1:0]];
			end
		endcase
	end

endmodule

`default_nettype wire

// File: registerFile.sv
`default_nettype none

module registerFile #(
	parameter int NumRegs = 16
) (
	input logic Clock,
	input logic reset,
	input logic [busPkg::WordWidth-1:0] busData,
	input logic [NumRegs-1:0] regIn,
	output logic [busPkg::WordWidth-1:0] regContents [NumRegs]
);

	// every register watches the bus and loads on its own strobe.
	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < NumRegs; i++) begin
				regContents[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NumRegs; i++) begin
				if (regIn[i]) begin
					regContents[i] <= busData; // one load per clock.
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

	parameter int ConstWidth = 19; // width of the immediate constant.

	typedef enum logic [4:0] {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opRor = 5'd7,
		opRol = 5'd8,
		opShr = 5'd9,
		opShl = 5'd11,
		opMul = 5'd15,
		opNeg = 5'd17,
		opNot = 5'd18
	} aluOp;

	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [14:0] unused;
	} regFormat;

	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic signed [ConstWidth-1:0] constant;
	} immFormat;

	// the same IR bits, read either as three registers or as two plus a constant.
	typedef union packed {
		regFormat asReg;
		immFormat asImm;
	} instructionWord;

endpackage

`default_nettype wire

// File: busPkg.sv
`default_nettype none

package busPkg;

	parameter int WordWidth = 32; // width of the bus and of every register.

	// one index per bus source, in priority order (lowest wins).
	typedef enum logic [4:0] {
		srcR0 = 5'd0, srcR1 = 5'd1, srcR2 = 5'd2, srcR3 = 5'd3,
		srcR4 = 5'd4, srcR5 = 5'd5, srcR6 = 5'd6, srcR7 = 5'd7,
		srcR8 = 5'd8, srcR9 = 5'd9, srcR10 = 5'd10, srcR11 = 5'd11,
		srcR12 = 5'd12, srcR13 = 5'd13, srcR14 = 5'd14, srcR15 = 5'd15,
		srcHi = 5'd16,
		srcLo = 5'd17,
		srcZHigh = 5'd18,
		srcZLow = 5'd19,
		srcPc = 5'd20,
		srcMdr = 5'd21,
		srcInPort = 5'd22,
		srcImmediate = 5'd23,
		srcNone = 5'd31 // nothing requested, bus reads zero.
	} busSource;

endpackage

`default_nettype wire
